//--- arch_state.sv
`include "rob_cfg.svh"

module arch_state import rob_pkg::*; (
    input  logic                  clk,
    input  logic                  rst_n,

    input  logic                  alloc_we,
    input  alloc_req_t            alloc,
    input  logic [`ROB_TAG_W-1:0] alloc_tag,

    input  logic                  commit_valid,
    input  commit_t               commit,

    input  logic                  clear_all,

    input  logic [`REG_W-1:0]     src_reg,
    output logic [`ROB_TAG_W-1:0] fwd_tag,
    input  logic                  fwd_done,
    input  logic [`DATA_W-1:0]    fwd_data,
    output src_t                  src
);

    logic [`DATA_W-1:0]    regs      [`REG_NUM];
    logic [`REG_NUM-1:0]   map_valid;
    logic [`ROB_TAG_W-1:0] map_tag   [`REG_NUM];
    logic                  rename_en;
    logic                  reg_we;

    // stores never own a destination, x0 is never renamed
    assign rename_en = alloc_we && (alloc.op != op_store) && (alloc.dest != '0);
    assign reg_we    = commit_valid && (commit.op != op_store) && (commit.dest != '0);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `REG_NUM; i++) begin
                regs[i] <= '0;
            end
        end else if (reg_we) begin
            regs[commit.dest] <= commit.data;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            map_valid <= '0;
        end else if (clear_all) begin
            map_valid <= '0;
        end else begin
            if (reg_we && (map_tag[commit.dest] == commit.tag)) begin
                map_valid[commit.dest] <= 1'b0;
            end
            // newer producer wins over a same-edge retire
            if (rename_en) begin
                map_valid[alloc.dest] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rename_en) begin
            map_tag[alloc.dest] <= alloc_tag;
        end
    end

    assign fwd_tag = map_tag[src_reg];

    always_comb begin
        src.tag = map_tag[src_reg];
        if ((src_reg == '0) || !map_valid[src_reg]) begin
            src.ready = 1'b1;
            src.tag   = '0;
            src.value = regs[src_reg];
        end else if (fwd_done) begin
            src.ready = 1'b1;
            src.value = fwd_data;
        end else begin
            src.ready = 1'b0;
            src.value = '0;
        end
    end

    a_x0_zero: assert property (@(posedge clk) disable iff (!rst_n)
        regs[0] == '0);

endmodule

//--- rob_cfg.svh
`ifndef ROB_CFG_SVH
`define ROB_CFG_SVH

// reorder buffer size, tag width must cover it
`define ROB_DEPTH 8
`define ROB_TAG_W 3

`define REG_NUM 32
`define REG_W 5
`define DATA_W 32
`define ADDR_W 32

`endif

//--- rob_ctrl.sv
`include "rob_cfg.svh"

module rob_ctrl import rob_pkg::*; (
    input  logic                  clk,
    input  logic                  rst_n,

    input  logic                  alloc_valid,
    input  alloc_req_t            alloc,
    output logic                  alloc_ready,
    output logic [`ROB_TAG_W-1:0] alloc_tag,

    input  entry_t                head_entry,
    output logic [`ROB_TAG_W-1:0] head_tag,

    output logic                  alloc_we,
    output logic                  clear_all,

    input  logic                  store_ack,
    output logic                  store_req_valid,
    output logic [`ROB_TAG_W-1:0] store_req_tag,

    output logic                  commit_valid,
    output commit_t               commit,

    output logic                  flush_valid,
    output logic [`ADDR_W-1:0]    redirect_pc
);

    localparam logic [`ROB_TAG_W:0] full_count = (`ROB_TAG_W+1)'(`ROB_DEPTH);

    logic [`ROB_TAG_W-1:0] head_q;
    logic [`ROB_TAG_W-1:0] tail_q;
    logic [`ROB_TAG_W:0]   count_q;
    commit_state_e         state_q;
    commit_state_e         state_d;
    logic [`ADDR_W-1:0]    redirect_q;
    logic                  head_ready;
    logic                  mispredict;
    logic                  take_flush;

    assign head_ready = head_entry.busy && head_entry.done;
    assign mispredict = (head_entry.op == op_branch) &&
                        (head_entry.pred_taken != head_entry.act_taken);

    assign alloc_ready = (count_q != full_count) && (state_q != cs_flush);
    assign alloc_we    = alloc_valid && alloc_ready;
    assign alloc_tag   = tail_q;
    assign head_tag    = head_q;

    assign store_req_valid = (state_q == cs_store_wait);
    assign store_req_tag   = head_q;

    // retirement record always describes the head
    assign commit.tag  = head_q;
    assign commit.dest = head_entry.dest;
    assign commit.data = head_entry.data;
    assign commit.op   = head_entry.op;

    always_comb begin
        state_d      = state_q;
        commit_valid = 1'b0;
        flush_valid  = 1'b0;
        case (state_q)
            cs_run: begin
                if (head_ready) begin
                    if (head_entry.op == op_store) begin
                        state_d = cs_store_wait;
                    end else begin
                        commit_valid = 1'b1;
                        if (mispredict) begin
                            state_d = cs_flush;
                        end
                    end
                end
            end
            cs_store_wait: begin
                if (store_ack) begin
                    commit_valid = 1'b1;
                    state_d      = cs_run;
                end
            end
            cs_flush: begin
                flush_valid = 1'b1;
                state_d     = cs_run;
            end
            default: state_d = cs_run;
        endcase
    end

    assign clear_all   = flush_valid;
    assign take_flush  = (state_q == cs_run) && (state_d == cs_flush);
    assign redirect_pc = redirect_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
            state_q <= cs_run;
        end else begin
            state_q <= state_d;
            if (flush_valid) begin
                head_q  <= '0;
                tail_q  <= '0;
                count_q <= '0;
            end else begin
                if (alloc_we) begin
                    tail_q <= tail_q + 1'b1;
                end
                if (commit_valid) begin
                    head_q <= head_q + 1'b1;
                end
                count_q <= count_q + {{`ROB_TAG_W{1'b0}}, alloc_we}
                                   - {{`ROB_TAG_W{1'b0}}, commit_valid};
            end
        end
    end

    // holds the mispredicted branch target for the flush cycle
    always_ff @(posedge clk) begin
        if (take_flush) begin
            redirect_q <= head_entry.target_pc;
        end
    end

    a_no_alloc_when_full: assert property (@(posedge clk) disable iff (!rst_n)
        (head_entry.busy && (head_q == tail_q)) |-> !alloc_we);

    a_flush_one_cycle: assert property (@(posedge clk) disable iff (!rst_n)
        flush_valid |=> !flush_valid);

    a_alloc_op_legal: assert property (@(posedge clk) disable iff (!rst_n)
        alloc_we |-> (alloc.op inside {op_alu, op_branch, op_store}));

endmodule

//--- rob_entry_file.sv
`include "rob_cfg.svh"

module rob_entry_file import rob_pkg::*; (
    input  logic                  clk,
    input  logic                  rst_n,

    input  logic                  alloc_we,
    input  logic [`ROB_TAG_W-1:0] alloc_idx,
    input  alloc_req_t            alloc,

    input  logic                  wb_valid,
    input  wb_t                   wb,

    input  logic                  clear_all,
    input  logic                  retire,

    input  logic [`ROB_TAG_W-1:0] head_tag,
    output entry_t                head_entry,

    input  logic [`ROB_TAG_W-1:0] fwd_tag,
    output logic                  fwd_done,
    output logic [`DATA_W-1:0]    fwd_data
);

    entry_t mem [`ROB_DEPTH];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `ROB_DEPTH; i++) begin
                mem[i].busy <= 1'b0;
                mem[i].done <= 1'b0;
            end
        end else if (clear_all) begin
            for (int i = 0; i < `ROB_DEPTH; i++) begin
                mem[i].busy <= 1'b0;
                mem[i].done <= 1'b0;
            end
        end else begin
            if (retire) begin
                mem[head_tag].busy <= 1'b0;
                mem[head_tag].done <= 1'b0;
            end
            if (alloc_we) begin
                mem[alloc_idx].busy       <= 1'b1;
                mem[alloc_idx].done       <= 1'b0;
                mem[alloc_idx].dest       <= alloc.dest;
                mem[alloc_idx].op         <= alloc.op;
                mem[alloc_idx].pred_taken <= alloc.pred_taken;
                mem[alloc_idx].act_taken  <= 1'b0;
            end
            // results land out of order against the tag
            if (wb_valid) begin
                mem[wb.tag].done      <= 1'b1;
                mem[wb.tag].data      <= wb.data;
                mem[wb.tag].act_taken <= wb.taken;
                mem[wb.tag].target_pc <= wb.target_pc;
            end
        end
    end

    assign head_entry = mem[head_tag];

    // forwarding read for the operand lookup
    assign fwd_done = mem[fwd_tag].busy && mem[fwd_tag].done;
    assign fwd_data = mem[fwd_tag].data;

    a_wb_to_pending: assert property (@(posedge clk) disable iff (!rst_n)
        wb_valid |-> (mem[wb.tag].busy && !mem[wb.tag].done));

endmodule

//--- rob_pkg.sv
`include "rob_cfg.svh"

package rob_pkg;

    typedef enum logic [1:0] {
        op_alu,
        op_branch,
        op_store
    } rob_op_e;

    typedef enum logic [1:0] {
        cs_run,
        cs_store_wait,
        cs_flush
    } commit_state_e;

    typedef struct packed {
        logic [`REG_W-1:0] dest;
        rob_op_e           op;
        logic              pred_taken;
    } alloc_req_t;

    typedef struct packed {
        logic [`ROB_TAG_W-1:0] tag;
        logic [`DATA_W-1:0]    data;
        logic                  taken;
        logic [`ADDR_W-1:0]    target_pc;
    } wb_t;

    typedef struct packed {
        logic               busy;
        logic               done;
        logic [`REG_W-1:0]  dest;
        rob_op_e            op;
        logic               pred_taken;
        logic               act_taken;
        logic [`DATA_W-1:0] data;
        logic [`ADDR_W-1:0] target_pc;
    } entry_t;

    typedef struct packed {
        logic [`ROB_TAG_W-1:0] tag;
        logic [`REG_W-1:0]     dest;
        logic [`DATA_W-1:0]    data;
        rob_op_e               op;
    } commit_t;

    // ready low means tag names the pending producer
    typedef struct packed {
        logic                  ready;
        logic [`ROB_TAG_W-1:0] tag;
        logic [`DATA_W-1:0]    value;
    } src_t;

endpackage

//--- rob_top.f
+incdir+.
rob_pkg.sv
rob_ctrl.sv
rob_entry_file.sv
arch_state.sv
rob_top.sv
tb_clk_gen.sv
tb_rob_top.sv

//--- rob_top.sv
`include "rob_cfg.svh"

module rob_top import rob_pkg::*; (
    input  logic                  clk,
    input  logic                  rst_n,

    input  logic                  alloc_valid,
    input  alloc_req_t            alloc,
    output logic                  alloc_ready,
    output logic [`ROB_TAG_W-1:0] alloc_tag,

    input  logic                  wb_valid,
    input  wb_t                   wb,

    input  logic [`REG_W-1:0]     src_reg,
    output src_t                  src,

    output logic                  commit_valid,
    output commit_t               commit,

    output logic                  store_req_valid,
    output logic [`ROB_TAG_W-1:0] store_req_tag,
    input  logic                  store_ack,

    output logic                  flush_valid,
    output logic [`ADDR_W-1:0]    redirect_pc
);

    logic                  alloc_we;
    logic                  clear_all;
    logic [`ROB_TAG_W-1:0] head_tag;
    entry_t                head_entry;
    logic [`ROB_TAG_W-1:0] fwd_tag;
    logic                  fwd_done;
    logic [`DATA_W-1:0]    fwd_data;

    rob_ctrl u_ctrl (
        .clk             (clk),
        .rst_n           (rst_n),
        .alloc_valid     (alloc_valid),
        .alloc           (alloc),
        .alloc_ready     (alloc_ready),
        .alloc_tag       (alloc_tag),
        .head_entry      (head_entry),
        .head_tag        (head_tag),
        .alloc_we        (alloc_we),
        .clear_all       (clear_all),
        .store_ack       (store_ack),
        .store_req_valid (store_req_valid),
        .store_req_tag   (store_req_tag),
        .commit_valid    (commit_valid),
        .commit          (commit),
        .flush_valid     (flush_valid),
        .redirect_pc     (redirect_pc)
    );

    // the commit pulse doubles as the retire strobe
    rob_entry_file u_entries (
        .clk        (clk),
        .rst_n      (rst_n),
        .alloc_we   (alloc_we),
        .alloc_idx  (alloc_tag),
        .alloc      (alloc),
        .wb_valid   (wb_valid),
        .wb         (wb),
        .clear_all  (clear_all),
        .retire     (commit_valid),
        .head_tag   (head_tag),
        .head_entry (head_entry),
        .fwd_tag    (fwd_tag),
        .fwd_done   (fwd_done),
        .fwd_data   (fwd_data)
    );

    arch_state u_arch (
        .clk          (clk),
        .rst_n        (rst_n),
        .alloc_we     (alloc_we),
        .alloc        (alloc),
        .alloc_tag    (alloc_tag),
        .commit_valid (commit_valid),
        .commit       (commit),
        .clear_all    (clear_all),
        .src_reg      (src_reg),
        .fwd_tag      (fwd_tag),
        .fwd_done     (fwd_done),
        .fwd_data     (fwd_data),
        .src          (src)
    );

endmodule

//--- run_sim.sh
#!/bin/sh
# build the reorder buffer testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module tb_rob_top -f rob_top.f
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

out=$(./obj_dir/Vtb_rob_top)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -qx "Verification passed"; then
    exit 0
fi
exit 1

//--- tb_clk_gen.sv
module tb_clk_gen (
    output logic clk,
    output logic rst_n
);
    timeunit 1ns;
    timeprecision 100ps;

    localparam int half_period = 10;

    initial begin
        clk = 1'b0;
        forever #(half_period) clk = ~clk;
    end

    // release on a falling edge, clear of the DUT's sampling edge
    initial begin
        rst_n = 1'b0;
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
    end

endmodule

//--- tb_rob_top.sv
`include "rob_cfg.svh"

module tb_rob_top import rob_pkg::*; ();
    timeunit 1ns;
    timeprecision 100ps;

    typedef struct packed {
        logic [`ROB_TAG_W-1:0] tag;
        logic [`REG_W-1:0]     dest;
        rob_op_e               op;
        logic                  pred;
        logic                  done;
        logic [`DATA_W-1:0]    data;
        logic                  taken;
        logic [`ADDR_W-1:0]    target;
    } model_entry_t;

    logic                  clk;
    logic                  rst_n;
    logic                  alloc_valid;
    alloc_req_t            alloc;
    logic                  alloc_ready;
    logic [`ROB_TAG_W-1:0] alloc_tag;
    logic                  wb_valid;
    wb_t                   wb;
    logic [`REG_W-1:0]     src_reg;
    src_t                  src;
    logic                  commit_valid;
    commit_t               commit;
    logic                  store_req_valid;
    logic [`ROB_TAG_W-1:0] store_req_tag;
    logic                  store_ack;
    logic                  flush_valid;
    logic [`ADDR_W-1:0]    redirect_pc;

    // reference model, rob_q[0] is the oldest entry
    model_entry_t          rob_q [$];
    logic [`DATA_W-1:0]    regs_m      [`REG_NUM];
    logic                  map_valid_m [`REG_NUM];
    logic [`ROB_TAG_W-1:0] map_tag_m   [`REG_NUM];
    logic [`ROB_TAG_W-1:0] tail_m;
    commit_state_e         state_m;
    commit_state_e         state_next;
    logic [`ADDR_W-1:0]    flush_pc;
    int                    ack_wait;

    // what the coming edge will do, decided while inputs are stable
    logic                  take_alloc;
    logic                  take_commit;
    logic                  take_flush;
    logic                  take_wb;
    alloc_req_t            alloc_seen;
    wb_t                   wb_seen;
    logic                  last_dest_valid;
    logic [`REG_W-1:0]     last_dest;

    logic [31:0]           rng_state;
    bit                    timed_out;
    int                    errors;
    int                    n_commits;
    int                    n_stores;
    int                    n_flushes;
    int                    n_full;

    tb_clk_gen clk_gen (
        .clk   (clk),
        .rst_n (rst_n)
    );

    rob_top uut (
        .clk             (clk),
        .rst_n           (rst_n),
        .alloc_valid     (alloc_valid),
        .alloc           (alloc),
        .alloc_ready     (alloc_ready),
        .alloc_tag       (alloc_tag),
        .wb_valid        (wb_valid),
        .wb              (wb),
        .src_reg         (src_reg),
        .src             (src),
        .commit_valid    (commit_valid),
        .commit          (commit),
        .store_req_valid (store_req_valid),
        .store_req_tag   (store_req_tag),
        .store_ack       (store_ack),
        .flush_valid     (flush_valid),
        .redirect_pc     (redirect_pc)
    );

    function automatic logic [31:0] next_random();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    task automatic report_mismatch(input string what, input logic [31:0] got,
                                   input logic [31:0] exp);
        $display("Error at %0t: %s is 0x%0h, expected 0x%0h", $time, what, got, exp);
        errors++;
    endtask

    // model transitions for the edge that just happened
    task automatic apply_edge();
        model_entry_t h;
        model_entry_t e;
        last_dest_valid = 1'b0;
        if (take_flush) begin
            rob_q.delete();
            tail_m = '0;
            for (int r = 0; r < `REG_NUM; r++) begin
                map_valid_m[r] = 1'b0;
            end
            n_flushes++;
        end else begin
            if (take_commit) begin
                h = rob_q.pop_front();
                n_commits++;
                if (h.op == op_store) begin
                    n_stores++;
                end else if (h.dest != '0) begin
                    regs_m[h.dest] = h.data;
                    if (map_valid_m[h.dest] && (map_tag_m[h.dest] == h.tag)) begin
                        map_valid_m[h.dest] = 1'b0;
                    end
                    last_dest_valid = 1'b1;
                    last_dest       = h.dest;
                end
                if ((h.op == op_branch) && (h.pred != h.taken)) begin
                    flush_pc = h.target;
                end
            end
            if (take_wb) begin
                for (int i = 0; i < rob_q.size(); i++) begin
                    if (rob_q[i].tag == wb_seen.tag) begin
                        e        = rob_q[i];
                        e.done   = 1'b1;
                        e.data   = wb_seen.data;
                        e.taken  = wb_seen.taken;
                        e.target = wb_seen.target_pc;
                        rob_q[i] = e;
                    end
                end
            end
            if (take_alloc) begin
                e.tag    = tail_m;
                e.dest   = alloc_seen.dest;
                e.op     = alloc_seen.op;
                e.pred   = alloc_seen.pred_taken;
                e.done   = 1'b0;
                e.data   = '0;
                e.taken  = 1'b0;
                e.target = '0;
                rob_q.push_back(e);
                if ((alloc_seen.op != op_store) && (alloc_seen.dest != '0)) begin
                    map_valid_m[alloc_seen.dest] = 1'b1;
                    map_tag_m[alloc_seen.dest]   = tail_m;
                end
                tail_m = tail_m + 1'b1;
            end
        end
        if ((state_m == cs_run) && (state_next == cs_store_wait)) begin
            ack_wait = int'(next_random() & 32'd7);
        end
        state_m = state_next;
    endtask

    task automatic drive_inputs(input bit allow_alloc, input logic [1:0] wb_rate);
        logic [31:0]  r;
        logic [31:0]  r2;
        model_entry_t pend [$];
        alloc_req_t   a;
        wb_t          w;
        int           pick;
        r = next_random();
        // mostly the low eight registers so producers collide
        a.dest = (r[1:0] != 2'd0) ? {2'b00, r[5:3]} : r[10:6];
        if (r[15:12] < 4'd9) begin
            a.op = op_alu;
        end else if (r[15:12] < 4'd13) begin
            a.op = op_branch;
        end else begin
            a.op = op_store;
        end
        a.pred_taken = r[16];
        alloc_valid <= allow_alloc && (r[19:17] < 3'd5);
        alloc       <= a;

        r  = next_random();
        r2 = next_random();
        w  = '0;
        for (int i = 0; i < rob_q.size(); i++) begin
            if (!rob_q[i].done) begin
                pend.push_back(rob_q[i]);
            end
        end
        if ((state_m != cs_flush) && (pend.size() > 0) && (r[1:0] < wb_rate)) begin
            pick        = int'(r[7:2]) % pend.size();
            w.tag       = pend[pick].tag;
            w.data      = next_random();
            w.target_pc = {r2[31:2], 2'b00};
            w.taken     = pend[pick].pred;
            if ((pend[pick].op == op_branch) && (r[10:8] < 3'd2)) begin
                w.taken = !pend[pick].pred;
            end
            wb_valid <= 1'b1;
        end else begin
            wb_valid <= 1'b0;
        end
        wb <= w;

        if ((state_m == cs_store_wait) && (ack_wait == 0)) begin
            store_ack <= 1'b1;
        end else begin
            store_ack <= 1'b0;
        end
        if ((state_m == cs_store_wait) && (ack_wait > 0)) begin
            ack_wait--;
        end

        r = next_random();
        if (last_dest_valid && r[0]) begin
            src_reg <= last_dest;
        end else if (r[2:1] == 2'd0) begin
            src_reg <= r[7:3];
        end else begin
            src_reg <= {2'b00, r[5:3]};
        end
    endtask

    task automatic check_outputs();
        model_entry_t          h;
        logic                  exp_ready;
        logic                  exp_sready;
        logic [`ROB_TAG_W-1:0] exp_stag;
        logic [`DATA_W-1:0]    exp_sval;
        h = '0;
        if (rob_q.size() > 0) begin
            h = rob_q[0];
        end
        exp_ready   = (rob_q.size() < `ROB_DEPTH) && (state_m != cs_flush);
        take_commit = 1'b0;
        take_flush  = 1'b0;
        state_next  = state_m;
        if (state_m == cs_run) begin
            if ((rob_q.size() > 0) && h.done) begin
                if (h.op == op_store) begin
                    state_next = cs_store_wait;
                end else begin
                    take_commit = 1'b1;
                    if ((h.op == op_branch) && (h.pred != h.taken)) begin
                        state_next = cs_flush;
                    end
                end
            end
        end else if (state_m == cs_store_wait) begin
            if (store_ack) begin
                take_commit = 1'b1;
                state_next  = cs_run;
            end
        end else begin
            take_flush = 1'b1;
            state_next = cs_run;
        end

        if (alloc_ready !== exp_ready)
            report_mismatch("alloc_ready", 32'(alloc_ready), 32'(exp_ready));
        if (alloc_tag !== tail_m)
            report_mismatch("alloc_tag", 32'(alloc_tag), 32'(tail_m));
        if (commit_valid !== take_commit)
            report_mismatch("commit_valid", 32'(commit_valid), 32'(take_commit));
        if (take_commit && (commit.tag !== h.tag))
            report_mismatch("commit tag", 32'(commit.tag), 32'(h.tag));
        if (take_commit && (commit.dest !== h.dest))
            report_mismatch("commit dest", 32'(commit.dest), 32'(h.dest));
        if (take_commit && (commit.op !== h.op))
            report_mismatch("commit op", 32'(commit.op), 32'(h.op));
        if (take_commit && (commit.data !== h.data))
            report_mismatch("commit data", commit.data, h.data);
        if (store_req_valid !== (state_m == cs_store_wait))
            report_mismatch("store_req_valid", 32'(store_req_valid),
                            32'(state_m == cs_store_wait));
        if ((state_m == cs_store_wait) && (store_req_tag !== h.tag))
            report_mismatch("store_req_tag", 32'(store_req_tag), 32'(h.tag));
        if (flush_valid !== take_flush)
            report_mismatch("flush_valid", 32'(flush_valid), 32'(take_flush));
        if (take_flush && (redirect_pc !== flush_pc))
            report_mismatch("redirect_pc", redirect_pc, flush_pc);

        // operand lookup through the rename map
        exp_sready = 1'b1;
        exp_stag   = '0;
        exp_sval   = regs_m[src_reg];
        if ((src_reg != '0) && map_valid_m[src_reg]) begin
            exp_stag   = map_tag_m[src_reg];
            exp_sready = 1'b0;
            exp_sval   = '0;
            foreach (rob_q[i]) begin
                if ((rob_q[i].tag == exp_stag) && rob_q[i].done) begin
                    exp_sready = 1'b1;
                    exp_sval   = rob_q[i].data;
                end
            end
        end
        if (src.ready !== exp_sready)
            report_mismatch("src ready", 32'(src.ready), 32'(exp_sready));
        else if (exp_sready && (src.value !== exp_sval))
            report_mismatch("src value", src.value, exp_sval);
        else if (!exp_sready && (src.tag !== exp_stag))
            report_mismatch("src tag", 32'(src.tag), 32'(exp_stag));

        take_alloc = alloc_valid && exp_ready;
        alloc_seen = alloc;
        take_wb    = wb_valid;
        wb_seen    = wb;
        if (!exp_ready && (rob_q.size() == `ROB_DEPTH)) begin
            n_full++;
        end
    endtask

    task automatic step_cycle(input bit allow_alloc, input logic [1:0] wb_rate);
        @(posedge clk);
        apply_edge();
        drive_inputs(allow_alloc, wb_rate);
        @(negedge clk);
        check_outputs();
    endtask

    initial begin
        int guard;
        rng_state   = 32'h4d24;
        alloc_valid = 1'b0;
        alloc       = '0;
        wb_valid    = 1'b0;
        wb          = '0;
        src_reg     = '0;
        store_ack   = 1'b0;
        for (int r = 0; r < `REG_NUM; r++) begin
            regs_m[r]      = '0;
            map_valid_m[r] = 1'b0;
            map_tag_m[r]   = '0;
        end
        tail_m      = '0;
        state_m     = cs_run;
        state_next  = cs_run;
        flush_pc    = '0;
        ack_wait    = 0;
        take_alloc  = 1'b0;
        take_commit = 1'b0;
        take_flush  = 1'b0;
        take_wb     = 1'b0;
        alloc_seen  = '0;
        wb_seen     = '0;
        last_dest_valid = 1'b0;
        last_dest   = '0;
        timed_out   = 1'b0;
        errors      = 0;
        n_commits   = 0;
        n_stores    = 0;
        n_flushes   = 0;
        n_full      = 0;

        guard = 0;
        while ((rst_n !== 1'b1) && !timed_out) begin
            @(posedge clk);
            guard++;
            if (guard > 20) begin
                $display("reset was never released");
                timed_out = 1'b1;
            end
        end

        // alternate slow and fast writeback phases so the buffer fills up
        for (int i = 0; (i < 3000) && !timed_out; i++) begin
            step_cycle(1'b1, ((i % 300) < 150) ? 2'd1 : 2'd3);
        end

        guard = 0;
        while (((rob_q.size() != 0) || (state_m != cs_run)) && !timed_out) begin
            step_cycle(1'b0, 2'd3);
            guard++;
            if (guard > 400) begin
                $display("buffer did not drain, %0d entries still in flight", rob_q.size());
                timed_out = 1'b1;
            end
        end

        if (!timed_out && ((n_flushes == 0) || (n_stores == 0) || (n_full == 0))) begin
            $display("random stimulus never reached a flush, a store and a full buffer");
            errors++;
        end

        $display("commits %0d, stores %0d, flushes %0d, full cycles %0d, errors %0d",
                 n_commits, n_stores, n_flushes, n_full, errors);
        if ((errors == 0) && !timed_out) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule
